// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mac_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | \
		awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: mac_accumulate_stage.sv
`timescale 1ns/10ps

module mac_accumulate_stage import mac_pkg::*; (
    input  logic       clk,
    input  logic       sync_clear,
    input  logic       in_valid,
    input  prod_beat_t in_beat,
    output logic       in_ready,
    output logic       out_valid,
    output acc_beat_t  out_beat,
    input  logic       out_ready
);

    prod_t acc_q;      // running sum
    prod_t sum_raw;    // wrapped sum
    prod_t sum_sat;    // saturated sum
    logic  sum_ovf;
    logic  fire;

    // ------------------------------
    // saturating add
    // ------------------------------
    assign sum_raw = acc_q + in_beat.prod;

    // overflow only when both addends agree in sign and the result does not
    assign sum_ovf = (in_beat.prod[PROD_W-1] == acc_q[PROD_W-1]) &&
                     (sum_raw[PROD_W-1] != in_beat.prod[PROD_W-1]);

    always_comb begin
        if (sum_ovf) begin
            sum_sat = in_beat.prod[PROD_W-1] ? PROD_MIN : PROD_MAX;  // by product sign
        end else begin
            sum_sat = sum_raw;
        end
    end

    // ------------------------------
    // handshake and registers
    // ------------------------------
    assign in_ready = ~out_valid | out_ready;
    assign fire     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (sync_clear) begin
            out_valid <= 1'b0;
            acc_q     <= '0;              // series restarts from zero
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            if (fire) begin
                // last closes the series, next one starts at zero
                acc_q <= in_beat.last ? '0 : sum_sat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_beat.sum  <= sum_sat;
            out_beat.last <= in_beat.last;
            out_beat.ovf  <= sum_ovf;
        end
    end

endmodule

// File: mac_core.sv
`timescale 1ns/10ps

module mac_core import mac_pkg::*; (
    input  logic     clk,
    input  logic     RESET_N,
    input  logic     init,
    output logic     ready,
    // operand A
    input  logic     a_valid,
    input  operand_t a_beat,
    output logic     a_ready,
    // operand B
    input  logic     b_valid,
    input  operand_t b_beat,
    output logic     b_ready,
    // result, sum of a*b over a series
    output logic     out_valid,
    output result_t  out_beat,
    input  logic     out_ready
);

    // ------------------------------
    // stage to stage wiring
    // ------------------------------
    logic       sync_clear;
    logic       pair_valid;
    pair_t      pair;
    logic       mul_in_ready;
    logic       mul_out_valid;
    prod_beat_t mul_beat;
    logic       acc_in_ready;
    acc_beat_t  acc_beat;

    mac_operand_join u_join (
        .clk        (clk),
        .RESET_N    (RESET_N),
        .init       (init),
        .a_valid    (a_valid),
        .a_beat     (a_beat),
        .b_valid    (b_valid),
        .b_beat     (b_beat),
        .pair_ready (mul_in_ready),
        .a_ready    (a_ready),
        .b_ready    (b_ready),
        .pair_valid (pair_valid),
        .pair       (pair),
        .sync_clear (sync_clear),
        .ready      (ready)
    );

    mac_multiply_stage u_mul (
        .clk        (clk),
        .sync_clear (sync_clear),
        .in_valid   (pair_valid),
        .in_pair    (pair),
        .in_ready   (mul_in_ready),
        .out_valid  (mul_out_valid),
        .out_beat   (mul_beat),
        .out_ready  (acc_in_ready)   // back-pressure from accumulator
    );

    // handshake goes straight to the result port
    mac_accumulate_stage u_acc (
        .clk        (clk),
        .sync_clear (sync_clear),
        .in_valid   (mul_out_valid),
        .in_beat    (mul_beat),
        .in_ready   (acc_in_ready),
        .out_valid  (out_valid),
        .out_beat   (acc_beat),
        .out_ready  (out_ready)
    );

    mac_result_narrow u_narrow (
        .in_beat  (acc_beat),
        .out_beat (out_beat)        // combinational, no added latency
    );

endmodule

// File: mac_core_assert.sv
`timescale 1ns/10ps

module mac_core_assert import mac_pkg::*; (
    input logic     clk,
    input logic     RESET_N,
    input logic     init,
    input logic     ready,
    input logic     sync_clear,
    input logic     a_valid,
    input operand_t a_beat,
    input logic     b_valid,
    input operand_t b_beat,
    input logic     out_valid,
    input result_t  out_beat,
    input logic     out_ready
);

    int fail_cnt = 0;   // assertion failures so far

    // both streams close a series on the same pair
    last_match: assert property (@(posedge clk) disable iff (!RESET_N)
        a_valid && b_valid |-> a_beat.last == b_beat.last)
        else begin
            $error("a_last and b_last differ on a paired beat");
            fail_cnt++;
        end

    // held result under back-pressure, a clear may still drop it
    out_hold: assert property (@(posedge clk) disable iff (!RESET_N)
        out_valid && !out_ready && !sync_clear |=> out_valid && $stable(out_beat))
        else begin
            $error("result beat changed while out_ready was low");
            fail_cnt++;
        end

    init_drops_ready: assert property (@(posedge clk) disable iff (!RESET_N)
        init |=> !ready)
        else begin
            $error("ready still high on the cycle after init");
            fail_cnt++;
        end

endmodule

bind mac_core mac_core_assert u_assert (.*);

// File: mac_multiply_stage.sv
`timescale 1ns/10ps

module mac_multiply_stage import mac_pkg::*; (
    input  logic       clk,
    input  logic       sync_clear,
    input  logic       in_valid,
    input  pair_t      in_pair,
    output logic       in_ready,
    output logic       out_valid,
    output prod_beat_t out_beat,
    input  logic       out_ready
);

    prod_t a_ext;   // sign-extended operands
    prod_t b_ext;
    prod_t prod;    // full width, cannot overflow

    assign a_ext = prod_t'(in_pair.a);
    assign b_ext = prod_t'(in_pair.b);
    assign prod  = a_ext * b_ext;

    // register free or being drained
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (sync_clear) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;   // bubble when nothing offered
        end
    end

    // payload only moves on an accepted beat
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_beat.prod <= prod;
            out_beat.last <= in_pair.last;
        end
    end

endmodule

// File: mac_operand_join.sv
`timescale 1ns/10ps

module mac_operand_join import mac_pkg::*; (
    input  logic     clk,
    input  logic     RESET_N,
    input  logic     init,        // level, clears the pipeline
    input  logic     a_valid,
    input  operand_t a_beat,
    input  logic     b_valid,
    input  operand_t b_beat,
    input  logic     pair_ready,  // multiply stage can take a pair
    output logic     a_ready,
    output logic     b_ready,
    output logic     pair_valid,
    output pair_t    pair,
    output logic     sync_clear,  // active high, one cycle behind init
    output logic     ready        // status, core usable
);

    // ------------------------------
    // operand pairing
    // ------------------------------
    assign pair_valid = a_valid & b_valid;  // need both sides

    // each side sees ready only when the other one is present,
    // so neither stream is consumed alone
    assign a_ready = pair_ready & b_valid;
    assign b_ready = pair_ready & a_valid;

    assign pair.a    = a_beat.data;
    assign pair.b    = b_beat.data;
    assign pair.last = a_beat.last & b_beat.last;  // both must close the series

    // ------------------------------
    // clear and status registers
    // ------------------------------
    // clear is the registered inverse of (RESET_N & ~init)
    always_ff @(posedge clk or negedge RESET_N) begin
        if (!RESET_N) begin
            sync_clear <= 1'b1;   // stages held empty during reset
        end else begin
            sync_clear <= init;
        end
    end

    always_ff @(posedge clk or negedge RESET_N) begin
        if (!RESET_N) begin
            ready <= 1'b0;
        end else begin
            ready <= ~init;       // drops for the cycle after init
        end
    end

endmodule

// File: mac_pkg.sv
package mac_pkg;

    // ------------------------------
    // widths and numeric types
    // ------------------------------
    localparam int DATA_W = 16;          // operand / result width
    localparam int PROD_W = 2 * DATA_W;  // full product, also accumulator

    typedef logic signed [DATA_W-1:0] data_t;  // operand or narrowed result
    typedef logic signed [PROD_W-1:0] prod_t;  // product or running sum

    // 2's complement limits
    localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};
    localparam prod_t PROD_MAX = {1'b0, {(PROD_W-1){1'b1}}};
    localparam prod_t PROD_MIN = {1'b1, {(PROD_W-1){1'b0}}};

    // ------------------------------
    // beats between the stages
    // ------------------------------
    typedef struct packed {
        data_t data;
        logic  last;
    } operand_t;                         // 17 bits, one stream beat

    typedef struct packed {
        data_t a;
        data_t b;
        logic  last;                     // a.last & b.last
    } pair_t;                            // 33 bits

    typedef struct packed {
        prod_t prod;
        logic  last;
    } prod_beat_t;                       // 33 bits

    typedef struct packed {
        prod_t sum;
        logic  last;
        logic  ovf;                      // accumulator saturated
    } acc_beat_t;                        // 34 bits

    typedef struct packed {
        data_t data;
        logic  last;
        logic  overflow;                 // either saturation hit
    } result_t;                          // 18 bits

endpackage

// File: mac_result_narrow.sv
`timescale 1ns/10ps

module mac_result_narrow import mac_pkg::*; (
    input  acc_beat_t in_beat,
    output result_t   out_beat
);

    // data limits at product width, sign extended
    localparam prod_t lim_hi = prod_t'(DATA_MAX);
    localparam prod_t lim_lo = prod_t'(DATA_MIN);

    always_comb begin
        out_beat.last = in_beat.last;
        if (in_beat.ovf) begin
            // accumulator already pinned, follow its sign
            out_beat.data     = in_beat.sum[PROD_W-1] ? DATA_MIN : DATA_MAX;
            out_beat.overflow = 1'b1;
        end else if (in_beat.sum > lim_hi) begin
            out_beat.data     = DATA_MAX;
            out_beat.overflow = 1'b1;
        end else if (in_beat.sum < lim_lo) begin
            out_beat.data     = DATA_MIN;
            out_beat.overflow = 1'b1;
        end else begin
            out_beat.data     = in_beat.sum[DATA_W-1:0];  // fits, plain truncate
            out_beat.overflow = 1'b0;
        end
    end

endmodule

// File: tb.f
mac_pkg.sv
mac_operand_join.sv
mac_multiply_stage.sv
mac_accumulate_stage.sv
mac_result_narrow.sv
mac_core.sv
mac_core_assert.sv
tb_mac_core.sv

// File: tb_mac_core.sv
`timescale 1ns/10ps

module tb_mac_core import mac_pkg::*; ();

    localparam int N_VEC    = 15;
    localparam int WD_LIMIT = N_VEC * 20 + 60;   // watchdog, clock cycles

    typedef struct packed {
        data_t a;
        data_t b;
        logic  a_last;
        logic  b_last;
        logic  init_before;   // pulse init before this beat
        data_t exp_data;
        logic  exp_ovf;
    } vec_t;

    logic     clk = 1'b0;
    logic     RESET_N;
    logic     init;
    logic     ready;
    logic     a_valid;
    operand_t a_beat;
    logic     a_ready;
    logic     b_valid;
    operand_t b_beat;
    logic     b_ready;
    logic     out_valid;
    result_t  out_beat;
    logic     out_ready;

    vec_t        vec_tab [N_VEC];
    logic [15:0] lfsr;
    int          n_got;        // results taken so far
    int          n_checks;
    int          n_errors;

    always #4 clk = ~clk;      // 8 ns period

    mac_core u_dut (
        .clk       (clk),
        .RESET_N   (RESET_N),
        .init      (init),
        .ready     (ready),
        .a_valid   (a_valid),
        .a_beat    (a_beat),
        .a_ready   (a_ready),
        .b_valid   (b_valid),
        .b_beat    (b_beat),
        .b_ready   (b_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic vec_t make_vec(input data_t a, input data_t b, input logic last,
                                      input logic clr, input data_t ed, input logic eo);
        return '{a: a, b: b, a_last: last, b_last: last, init_before: clr,
                 exp_data: ed, exp_ovf: eo};
    endfunction

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);   // one step per bit
    endtask

    task automatic check_value(input string name, input logic signed [31:0] got,
                               input logic signed [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // operand driver
    // ------------------------------
    // empties the pipe, then init for one cycle
    task automatic pulse_init(input int n);
        @(posedge clk);
        #1;
        a_valid = 1'b0;
        b_valid = 1'b0;
        while (n_got < n) begin
            @(posedge clk);
            #1;
        end
        init = 1'b1;
        @(posedge clk);
        #1;
        init = 1'b0;
        check_value("ready", 32'(ready), 32'd0);   // low after the init edge
        @(posedge clk);
        #1;
        check_value("ready", 32'(ready), 32'd1);
        @(negedge clk);
    endtask

    task automatic drive_operands();
        int   i;
        logic gap;
        logic fired;
        @(negedge clk);                    // decisions on the falling edge
        for (i = 0; i < N_VEC; i++) begin
            if (vec_tab[i].init_before) begin
                pulse_init(i);
            end
            draw_bit(gap);
            @(posedge clk);
            #1;
            if (gap) begin                 // one cycle with a single side valid
                a_beat  = '{data: vec_tab[i].a, last: vec_tab[i].a_last};
                b_beat  = '{data: vec_tab[i].b, last: vec_tab[i].b_last};
                a_valid = i[0];            // odd beats offer A first, even ones B
                b_valid = ~i[0];
                @(negedge clk);
                if (i[0]) begin
                    check_value("a_ready", 32'(a_ready), 32'd0);  // B missing
                end else begin
                    check_value("b_ready", 32'(b_ready), 32'd0);  // A missing
                end
                @(posedge clk);
                #1;
            end
            a_beat  = '{data: vec_tab[i].a, last: vec_tab[i].a_last};
            b_beat  = '{data: vec_tab[i].b, last: vec_tab[i].b_last};
            a_valid = 1'b1;
            b_valid = 1'b1;
            fired   = 1'b0;
            while (!fired) begin
                @(negedge clk);
                fired = a_ready & b_ready; // pair taken on the next edge
            end
        end
        @(posedge clk);
        #1;
        a_valid = 1'b0;
        b_valid = 1'b0;
    endtask

    // ------------------------------
    // result collector
    // ------------------------------
    task automatic collect_results();
        logic stall;
        vec_t v;
        while (n_got < N_VEC) begin
            @(posedge clk);
            #1;
            draw_bit(stall);
            out_ready = ~stall;
            @(negedge clk);
            if (out_valid && out_ready) begin
                v = vec_tab[n_got];
                check_value("out_beat.data", 32'(out_beat.data), 32'(v.exp_data));
                check_value("out_beat.overflow", 32'(out_beat.overflow), 32'(v.exp_ovf));
                check_value("out_beat.last", 32'(out_beat.last), 32'(v.a_last & v.b_last));
                n_got++;
            end
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;   // lets any stray beat show
    endtask

    initial begin
        RESET_N   = 1'b0;
        init      = 1'b0;
        a_valid   = 1'b0;
        b_valid   = 1'b0;
        a_beat    = '0;
        b_beat    = '0;
        out_ready = 1'b0;
        lfsr      = 16'd71;
        n_got     = 0;
        n_checks  = 0;
        n_errors  = 0;
        // a, b, last, init before, expected running sum narrowed, overflow
        vec_tab[0]  = make_vec(16'sd3, 16'sd4, 1'b1, 1'b0, 16'sd12, 1'b0);
        vec_tab[1]  = make_vec(-16'sd5, 16'sd7, 1'b1, 1'b0, -16'sd35, 1'b0);
        vec_tab[2]  = make_vec(16'sd100, 16'sd2, 1'b0, 1'b0, 16'sd200, 1'b0);
        vec_tab[3]  = make_vec(16'sd50, -16'sd3, 1'b0, 1'b0, 16'sd50, 1'b0);
        vec_tab[4]  = make_vec(16'sd10, 16'sd10, 1'b1, 1'b0, 16'sd150, 1'b0);
        vec_tab[5]  = make_vec(16'sd300, 16'sd200, 1'b1, 1'b0, 16'sh7fff, 1'b1);
        vec_tab[6]  = make_vec(-16'sd300, 16'sd200, 1'b1, 1'b0, 16'sh8000, 1'b1);
        vec_tab[7]  = make_vec(16'sd8000, 16'sd8, 1'b0, 1'b0, 16'sh7fff, 1'b1);
        vec_tab[8]  = make_vec(-16'sd8000, 16'sd8, 1'b1, 1'b0, 16'sd0, 1'b0);
        vec_tab[9]  = make_vec(16'sh8000, 16'sh8000, 1'b0, 1'b0, 16'sh7fff, 1'b1);
        vec_tab[10] = make_vec(16'sh8000, 16'sh8000, 1'b1, 1'b0, 16'sh7fff, 1'b1);
        vec_tab[11] = make_vec(16'sd2, 16'sd2, 1'b1, 1'b0, 16'sd4, 1'b0);
        vec_tab[12] = make_vec(16'sd7, 16'sd1, 1'b0, 1'b0, 16'sd7, 1'b0);
        vec_tab[13] = make_vec(16'sd1, 16'sd1, 1'b1, 1'b1, 16'sd1, 1'b0); // sum cleared
        vec_tab[14] = make_vec(-16'sd2, 16'sd3, 1'b1, 1'b0, -16'sd6, 1'b0);

        repeat (3) @(posedge clk);
        #1;
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("ready", 32'(ready), 32'd0);
        RESET_N = 1'b1;
        @(posedge clk);
        #1;
        check_value("ready", 32'(ready), 32'd1);   // init low, core usable
        check_value("out_valid", 32'(out_valid), 32'd0);

        fork
            drive_operands();
            collect_results();
        join

        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);   // no duplicates
        end
        n_errors += u_dut.u_assert.fail_cnt;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, u_dut.u_assert.fail_cnt);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WD_LIMIT * 8);
        $display("timeout: only %0d of %0d results arrived", n_got, N_VEC);
        $display("Some tests failed");
        $finish;
    end

endmodule
